// ==== all.f ====
+incdir+.
cache_addr_pkg.sv
cache_line_pkg.sv
cache_req_decode.sv
cache_way.sv
cache_hit_merge.sv
dcache_top.sv
tb_dcache.sv

// ==== cache_addr_pkg.sv ====
`include "cache_params.svh"

package cache_addr_pkg;

    // one 32-bit byte address, seen either as a plain word
    // or split into the fields the cache indexes with
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            // compared against the stored tag
            logic [`TAG_W-1:0]    tag;
            // selects the set
            logic [`INDEX_W-1:0]  index;
            // byte within the line
            logic [`OFFSET_W-1:0] offset;
        } f;
    } cache_addr_u;

endpackage

// ==== cache_hit_merge.sv ====
`timescale 1ns/1ns

`include "cache_params.svh"

module cache_hit_merge (
    input  logic                              clk,
    input  logic                              rstn,

    input  logic                              s2_valid,
    input  logic                              s2_read,
    input  logic                              s2_lsq,
    input  logic [`CACHE_WAYS-1:0]            way_hit,
    input  logic [`CACHE_WAYS-1:0][31:0]      way_data,

    output logic                              rd_valid,
    output logic [31:0]                       rd_data,
    output logic                              miss
);

    logic [31:0] merged_data;
    logic        any_hit;
    logic        load_done;

    assign any_hit   = |way_hit;
    assign load_done = s2_valid && s2_read;

    // at most one way hits, so an OR is enough
    always_comb begin
        merged_data = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                merged_data = merged_data | way_data[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
            miss     <= 1'b0;
        end else begin
            rd_valid <= load_done;
            if (load_done) begin
                if (s2_lsq) begin
                    // forwarded by the LSQ, nothing to report
                    rd_data <= '0;
                    miss    <= 1'b0;
                end else begin
                    rd_data <= merged_data;
                    miss    <= !any_hit;
                end
            end else begin
                // miss only means something alongside rd_valid
                miss <= 1'b0;
            end
        end
    end

endmodule

// ==== cache_line_pkg.sv ====
`include "cache_params.svh"

package cache_line_pkg;

    // one cache line, little-endian
    // halves[j] overlays bytes[2j] (low) and bytes[2j+1] (high)
    typedef union packed {
        // byte lanes, lane 0 in the low bits
        logic [`LINE_BYTES-1:0][7:0] bytes;
        // halfword lanes, offset bit 0 dropped
        logic [`LINE_W/16-1:0][15:0] halves;
    } cache_line_u;

endpackage

// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_WAYS      4
`define CACHE_SETS      128
`define LINE_BYTES      64

// victim pointer width, log2 of the way count
`define WAY_PTR_W       2

// address split: tag | index | offset
`define TAG_W           19
`define INDEX_W         7
`define OFFSET_W        6

// full line in bits
`define LINE_W          (`LINE_BYTES * 8)

// request to result, in clock edges
// decoder stage, way stage, merge stage
`define DCACHE_LATENCY  3

`endif

// ==== cache_req_decode.sv ====
`timescale 1ns/1ns

`include "cache_params.svh"

module cache_req_decode
    import cache_addr_pkg::*;
    import cache_line_pkg::*;
(
    input  logic                      clk,
    input  logic                      rstn,

    input  logic                      req_valid,
    input  logic                      req_read,
    input  logic                      req_write,
    input  logic                      req_size,
    input  logic                      lsq_fwd,
    input  cache_addr_u               addr,
    input  logic [31:0]               store_data,

    input  logic                      fill_valid,
    input  cache_addr_u               fill_addr,
    input  cache_line_u               fill_line,

    output logic                      s1_valid,
    output logic                      s1_read,
    output logic                      s1_write,
    output logic                      s1_size,
    output logic                      s1_lsq,
    output logic                      s1_fill,
    output logic [`TAG_W-1:0]         s1_tag,
    output logic [`INDEX_W-1:0]       s1_index,
    output logic [`OFFSET_W-1:0]      s1_offset,
    output logic [31:0]               s1_store_data,
    output cache_line_u               s1_fill_line,
    output logic [`CACHE_WAYS-1:0]    fill_sel
);

    // next victim per set, advanced on every fill to that set
    logic [`WAY_PTR_W-1:0] victim_ptr [`CACHE_SETS];

    cache_addr_u           sel_addr;
    logic [`WAY_PTR_W-1:0] cur_ptr;

    // fill and request never come in the same cycle
    assign sel_addr = fill_valid ? fill_addr : addr;
    assign cur_ptr  = victim_ptr[sel_addr.f.index];

    // control stage, cleared on reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s1_read  <= 1'b0;
            s1_write <= 1'b0;
            s1_fill  <= 1'b0;
            fill_sel <= '0;
        end else begin
            s1_valid <= req_valid;
            s1_read  <= req_valid & req_read;
            s1_write <= req_valid & req_write;
            s1_fill  <= fill_valid;
            if (fill_valid) begin
                fill_sel <= `CACHE_WAYS'(1) << cur_ptr;
            end else begin
                fill_sel <= '0;
            end
        end
    end

    // round-robin victim pointers
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                victim_ptr[s] <= '0;
            end
        end else if (fill_valid) begin
            if (cur_ptr == `WAY_PTR_W'(`CACHE_WAYS - 1)) begin
                victim_ptr[sel_addr.f.index] <= '0;
            end else begin
                victim_ptr[sel_addr.f.index] <= cur_ptr + 1'b1;
            end
        end
    end

    // payload, only loaded when something arrives
    always_ff @(posedge clk) begin
        if (req_valid || fill_valid) begin
            s1_tag    <= sel_addr.f.tag;
            s1_index  <= sel_addr.f.index;
            s1_offset <= sel_addr.f.offset;
        end
        if (req_valid) begin
            s1_size       <= req_size;
            s1_lsq        <= lsq_fwd;
            s1_store_data <= store_data;
        end
        if (fill_valid) begin
            s1_fill_line <= fill_line;
        end
    end

endmodule

// ==== cache_way.sv ====
`timescale 1ns/1ns

`include "cache_params.svh"

module cache_way
    import cache_line_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,

    input  logic                   s1_valid,
    input  logic                   s1_read,
    input  logic                   s1_write,
    input  logic                   s1_size,
    input  logic                   s1_lsq,
    input  logic                   s1_fill,
    input  logic [`TAG_W-1:0]      s1_tag,
    input  logic [`INDEX_W-1:0]    s1_index,
    input  logic [`OFFSET_W-1:0]   s1_offset,
    input  logic [31:0]            s1_store_data,
    input  cache_line_u            s1_fill_line,
    input  logic                   fill_en,

    output logic                   hit,
    output logic [31:0]            load_data,
    output logic                   s2_valid,
    output logic                   s2_read,
    output logic                   s2_lsq
);

    logic [`TAG_W-1:0]      tag_mem  [`CACHE_SETS];
    cache_line_u            data_mem [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_q;

    cache_line_u            cur_line;
    cache_line_u            merged_line;
    logic                   tag_match;
    logic [31:0]            lane_data;
    logic                   do_fill;
    logic                   do_store;

    assign cur_line  = data_mem[s1_index];
    assign tag_match = valid_q[s1_index] && (tag_mem[s1_index] == s1_tag);
    assign do_fill   = s1_fill && fill_en;
    assign do_store  = s1_valid && s1_write && tag_match;

    // lane select and store merge on the addressed line
    always_comb begin
        merged_line = cur_line;
        if (s1_size) begin
            lane_data = {24'b0, cur_line.bytes[s1_offset]};
            merged_line.bytes[s1_offset] = s1_store_data[7:0];
        end else begin
            // halfword lanes are aligned, low offset bit ignored
            lane_data = {16'b0, cur_line.halves[s1_offset[`OFFSET_W-1:1]]};
            merged_line.halves[s1_offset[`OFFSET_W-1:1]] = s1_store_data[15:0];
        end
    end

    // valid bits are the only array state with a reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (do_fill) begin
            valid_q[s1_index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (do_fill) begin
            tag_mem[s1_index]  <= s1_tag;
            data_mem[s1_index] <= s1_fill_line;
        end else if (do_store) begin
            data_mem[s1_index] <= merged_line;
        end
    end

    // stage 2 control
    always_ff @(posedge clk) begin
        if (!rstn) begin
            hit      <= 1'b0;
            s2_valid <= 1'b0;
            s2_read  <= 1'b0;
            s2_lsq   <= 1'b0;
        end else begin
            hit      <= s1_valid && tag_match;
            s2_valid <= s1_valid;
            s2_read  <= s1_read;
            s2_lsq   <= s1_lsq;
        end
    end

    // zero unless this way hits a read
    always_ff @(posedge clk) begin
        if (s1_valid && s1_read && tag_match) begin
            load_data <= lane_data;
        end else begin
            load_data <= '0;
        end
    end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ns

`include "cache_params.svh"

module dcache_top
    import cache_addr_pkg::*;
    import cache_line_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,

    input  logic          req_valid,
    input  logic          req_read,
    input  logic          req_write,
    input  logic          req_size,
    input  logic          lsq_fwd,
    input  cache_addr_u   addr,
    input  logic [31:0]   store_data,

    input  logic          fill_valid,
    input  cache_addr_u   fill_addr,
    input  cache_line_u   fill_line,

    output logic          rd_valid,
    output logic [31:0]   rd_data,
    output logic          miss
);

    logic                          s1_valid;
    logic                          s1_read;
    logic                          s1_write;
    logic                          s1_size;
    logic                          s1_lsq;
    logic                          s1_fill;
    logic [`TAG_W-1:0]             s1_tag;
    logic [`INDEX_W-1:0]           s1_index;
    logic [`OFFSET_W-1:0]          s1_offset;
    logic [31:0]                   s1_store_data;
    cache_line_u                   s1_fill_line;
    logic [`CACHE_WAYS-1:0]        fill_sel;

    logic [`CACHE_WAYS-1:0]        way_hit;
    logic [`CACHE_WAYS-1:0][31:0]  way_data;
    // all ways carry identical copies, merge takes way 0
    logic [`CACHE_WAYS-1:0]        way_s2_valid;
    logic [`CACHE_WAYS-1:0]        way_s2_read;
    logic [`CACHE_WAYS-1:0]        way_s2_lsq;

    cache_req_decode u_decode (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req_read      (req_read),
        .req_write     (req_write),
        .req_size      (req_size),
        .lsq_fwd       (lsq_fwd),
        .addr          (addr),
        .store_data    (store_data),
        .fill_valid    (fill_valid),
        .fill_addr     (fill_addr),
        .fill_line     (fill_line),
        .s1_valid      (s1_valid),
        .s1_read       (s1_read),
        .s1_write      (s1_write),
        .s1_size       (s1_size),
        .s1_lsq        (s1_lsq),
        .s1_fill       (s1_fill),
        .s1_tag        (s1_tag),
        .s1_index      (s1_index),
        .s1_offset     (s1_offset),
        .s1_store_data (s1_store_data),
        .s1_fill_line  (s1_fill_line),
        .fill_sel      (fill_sel)
    );

    for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
        cache_way u_way (
            .clk           (clk),
            .rstn          (rstn),
            .s1_valid      (s1_valid),
            .s1_read       (s1_read),
            .s1_write      (s1_write),
            .s1_size       (s1_size),
            .s1_lsq        (s1_lsq),
            .s1_fill       (s1_fill),
            .s1_tag        (s1_tag),
            .s1_index      (s1_index),
            .s1_offset     (s1_offset),
            .s1_store_data (s1_store_data),
            .s1_fill_line  (s1_fill_line),
            .fill_en       (fill_sel[g]),
            .hit           (way_hit[g]),
            .load_data     (way_data[g]),
            .s2_valid      (way_s2_valid[g]),
            .s2_read       (way_s2_read[g]),
            .s2_lsq        (way_s2_lsq[g])
        );
    end

    cache_hit_merge u_merge (
        .clk      (clk),
        .rstn     (rstn),
        .s2_valid (way_s2_valid[0]),
        .s2_read  (way_s2_read[0]),
        .s2_lsq   (way_s2_lsq[0]),
        .way_hit  (way_hit),
        .way_data (way_data),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .miss     (miss)
    );

endmodule

// ==== dcache_vectors.txt ====
# op size lsq addr sdata exp_data exp_miss  (addr, sdata, exp_data in hex)
# op: R read, W write, F fill, I idle; size 1 = byte, 0 = halfword
# after reset every read misses
R 1 0 00000000 0 00000000 1
R 0 0 00024080 0 00000000 1
# set 2 tag 12, line bytes run 1a..59
F 0 0 00024080 0 00000000 0
R 1 0 00024080 0 0000001a 0
R 1 0 00024085 0 0000001f 0
R 1 0 000240bf 0 00000059 0
R 0 0 00024090 0 00002b2a 0
R 0 0 000240a1 0 00003b3a 0
R 0 0 000240be 0 00005958 0
# set 3 tag f0, byte values wrap past ff
F 0 0 001e00c0 0 00000000 0
I 0 0 00000000 0 00000000 0
R 0 0 001e00c2 0 0000fffe 0
R 0 0 001e00c4 0 00000100 0
R 1 0 001e00c4 0 00000000 0
# stores that hit
W 1 0 00024085 000000a5 00000000 0
W 0 0 00024091 0000beef 00000000 0
R 1 0 00024085 0 000000a5 0
R 1 0 00024084 0 0000001e 0
R 0 0 00024084 0 0000a51e 0
R 0 0 00024090 0 0000beef 0
R 1 0 00024091 0 000000be 0
R 1 0 0002408f 0 00000029 0
R 1 0 00024092 0 0000002c 0
# store that misses leaves everything alone
W 1 0 00044080 00000077 00000000 0
R 1 0 00044080 0 00000000 1
R 1 0 00024080 0 0000001a 0
# lsq forwarded reads
R 1 1 00024080 0 00000000 0
R 0 1 00000000 0 00000000 0
# five fills to set 5, tag 31 gets evicted
F 0 0 00062140 0 00000000 0
F 0 0 00064140 0 00000000 0
F 0 0 00066140 0 00000000 0
F 0 0 00068140 0 00000000 0
F 0 0 0006a140 0 00000000 0
R 1 0 00062140 0 00000000 1
R 1 0 00064140 0 00000046 0
R 1 0 00066141 0 00000048 0
R 1 0 00068142 0 0000004a 0
R 1 0 0006a143 0 0000004c 0
R 0 0 0006a140 0 00004a49 0
# back to back stores and reads
W 1 0 00024086 00000066 00000000 0
R 1 0 00024086 0 00000066 0
R 0 0 00024086 0 00002166 0
W 0 0 00024080 00001234 00000000 0
R 0 0 00024081 0 00001234 0
R 1 0 00024085 0 000000a5 0

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_dcache -o tb_dcache_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_dcache_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== tb_dcache.sv ====
`timescale 1ns/1ns

`include "cache_params.svh"

module tb_dcache
    import cache_addr_pkg::*;
    import cache_line_pkg::*;
();

    logic          clk = 1'b0;
    logic          rstn;
    logic          req_valid;
    logic          req_read;
    logic          req_write;
    logic          req_size;
    logic          lsq_fwd;
    cache_addr_u   addr;
    logic [31:0]   store_data;
    logic          fill_valid;
    cache_addr_u   fill_addr;
    cache_line_u   fill_line;
    logic          rd_valid;
    logic [31:0]   rd_data;
    logic          miss;

    // vectors as read from the file
    logic [7:0]    v_op[$];
    logic          v_size[$];
    logic          v_lsq[$];
    logic [31:0]   v_addr[$];
    logic [31:0]   v_sdata[$];
    logic [31:0]   v_data[$];
    logic          v_miss[$];

    // outstanding reads in issue order
    logic [31:0]   exp_data_q[$];
    logic          exp_miss_q[$];
    int            exp_due_q[$];
    string         exp_name_q[$];

    int            cyc = 0;
    int            limit = 0;
    int            data_errs = 0;
    int            miss_errs = 0;
    int            hs_errs = 0;
    int            other_errs = 0;

    dcache_top dut0 (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_read   (req_read),
        .req_write  (req_write),
        .req_size   (req_size),
        .lsq_fwd    (lsq_fwd),
        .addr       (addr),
        .store_data (store_data),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_line  (fill_line),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .miss       (miss)
    );

    always #5 clk = ~clk;

    // byte k of a filled line is low tag byte + 4 * index + k
    function automatic cache_line_u make_fill_line(input cache_addr_u a);
        cache_line_u line;
        for (int k = 0; k < `LINE_BYTES; k++) begin
            line.bytes[k] = 8'(a.f.tag[7:0] + 4 * a.f.index + k);
        end
        return line;
    endfunction

    task automatic check_load_data(input logic [31:0] got, input logic [31:0] exp,
                                   input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s rd_data got %08h expected %08h",
                     $time, what, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_miss(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s miss got %0b expected %0b", $time, what, got, exp);
            miss_errs++;
        end
    endtask

    task automatic load_vectors();
        int         fd;
        int         n;
        int         sz;
        int         lq;
        int         ms;
        string      line;
        logic [7:0] op;
        logic [31:0] ad;
        logic [31:0] sd;
        logic [31:0] dt;
        fd = $fopen("dcache_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open dcache_vectors.txt");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // blank lines and # comments carry no vector
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %d %d %h %h %h %d", op, sz, lq, ad, sd, dt, ms);
                    if (n == 7 && (op == "R" || op == "W" || op == "F" || op == "I")) begin
                        v_op.push_back(op);
                        v_size.push_back(sz[0]);
                        v_lsq.push_back(lq[0]);
                        v_addr.push_back(ad);
                        v_sdata.push_back(sd);
                        v_data.push_back(dt);
                        v_miss.push_back(ms[0]);
                    end else begin
                        $display("unreadable vector line: %s", line);
                        other_errs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_inputs();
        req_valid  <= 1'b0;
        req_read   <= 1'b0;
        req_write  <= 1'b0;
        fill_valid <= 1'b0;
    endtask

    task automatic drive_vector(input int i);
        logic [31:0] rnd;
        cache_addr_u a;
        rnd   = $urandom;
        a.raw = v_addr[i];
        idle_inputs();
        req_size   <= v_size[i];
        lsq_fwd    <= v_lsq[i];
        addr       <= a;
        store_data <= rnd;
        case (v_op[i])
            "R": begin
                req_valid <= 1'b1;
                req_read  <= 1'b1;
                // seen at the negedge right after the result edge
                exp_due_q.push_back(cyc + `DCACHE_LATENCY + 1);
                exp_data_q.push_back(v_data[i]);
                exp_miss_q.push_back(v_miss[i]);
                exp_name_q.push_back($sformatf("vector %0d read %08h", i, v_addr[i]));
            end
            "W": begin
                req_valid <= 1'b1;
                req_write <= 1'b1;
                // lanes outside the store size stay random
                if (v_size[i]) begin
                    store_data <= {rnd[31:8], v_sdata[i][7:0]};
                end else begin
                    store_data <= {rnd[31:16], v_sdata[i][15:0]};
                end
            end
            "F": begin
                fill_valid <= 1'b1;
                fill_addr  <= a;
                fill_line  <= make_fill_line(a);
            end
            default: begin
            end
        endcase
    endtask

    // result monitor on the falling edge
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rd_valid) begin
            if (exp_due_q.size() == 0) begin
                $display("unexpected rd_valid at %0t with no read outstanding", $time);
                hs_errs++;
            end else begin
                if (exp_due_q[0] != cyc) begin
                    $display("rd_valid for %s arrived at %0t, %0d cycles off its slot",
                             exp_name_q[0], $time, cyc - exp_due_q[0]);
                    hs_errs++;
                end
                check_load_data(rd_data, exp_data_q[0], exp_name_q[0]);
                check_miss(miss, exp_miss_q[0], exp_name_q[0]);
                void'(exp_due_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_miss_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end else if (exp_due_q.size() > 0 && exp_due_q[0] <= cyc) begin
            $display("missing rd_valid at %0t for %s", $time, exp_name_q[0]);
            hs_errs++;
            void'(exp_due_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_miss_q.pop_front());
            void'(exp_name_q.pop_front());
        end
    end

    initial begin
        wait (limit > 0);
        while (cyc < limit) begin
            @(negedge clk);
        end
        $display("timeout: run went past %0d cycles with reads still pending", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_read   = 1'b0;
        req_write  = 1'b0;
        req_size   = 1'b0;
        lsq_fwd    = 1'b0;
        addr       = '0;
        store_data = '0;
        fill_valid = 1'b0;
        fill_addr  = '0;
        fill_line  = '0;
        void'($urandom(30916));
        load_vectors();
        if (v_op.size() == 0) begin
            $display("no vectors to run");
            other_errs++;
        end else begin
            limit = v_op.size() + `DCACHE_LATENCY + 50;
            repeat (3) @(posedge clk);
            rstn <= 1'b1;
            for (int i = 0; i < v_op.size(); i++) begin
                @(posedge clk);
                drive_vector(i);
            end
            @(posedge clk);
            idle_inputs();
            while (exp_due_q.size() != 0) begin
                @(negedge clk);
            end
            repeat (2) @(negedge clk);
        end
        $display("errors: data %0d, miss %0d, handshake %0d, other %0d",
                 data_errs, miss_errs, hs_errs, other_errs);
        if (data_errs + miss_errs + hs_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
